// File: verilog/rv_isa_pkg.sv
// RV32I encoding package; imported by every stage that decodes fields or carries data words
package rv_isa_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================
  localparam int unsigned XLEN       = 32;
  localparam int unsigned ILEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  // Architectural register count, x0 included
  localparam int unsigned NUM_REGS   = 2 ** REG_ADDR_W;
  // Shift amount width follows the data width
  localparam int unsigned SHAMT_W    = $clog2(XLEN);

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [ILEN-1:0]       instr_t;
  typedef logic [6:0]            opcode_t;
  typedef logic [2:0]            funct3_t;
  typedef logic [6:0]            funct7_t;
  typedef logic [SHAMT_W-1:0]    shamt_t;

  // ==========================================================================
  // Opcodes and function fields
  // ==========================================================================
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;

  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  // Shared by SRL and SRA, funct7 tells them apart
  localparam funct3_t F3_SR      = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  localparam funct7_t F7_BASE    = 7'b0000000;
  // Alternate form, selects SUB and SRA
  localparam funct7_t F7_ALT     = 7'b0100000;

  // ==========================================================================
  // Field extraction, fixed positions of the R/I/U formats
  // ==========================================================================
  function automatic opcode_t instr_opcode(instr_t instr);
    return instr[6:0];
  endfunction

  function automatic reg_addr_t instr_rd(instr_t instr);
    return instr[11:7];
  endfunction

  function automatic funct3_t instr_funct3(instr_t instr);
    return instr[14:12];
  endfunction

  function automatic reg_addr_t instr_rs1(instr_t instr);
    return instr[19:15];
  endfunction

  function automatic reg_addr_t instr_rs2(instr_t instr);
    return instr[24:20];
  endfunction

  function automatic funct7_t instr_funct7(instr_t instr);
    return instr[31:25];
  endfunction

endpackage

// File: verilog/rv_pipe_pkg.sv
// Pipeline control package; imported where ALU operations, exceptions or operand selects travel
package rv_pipe_pkg;

  // ==========================================================================
  // ALU operations
  // ==========================================================================
  localparam int unsigned ALU_OP_W = 4;

  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_SLT    = 4'd8,
    ALU_SLTU   = 4'd9,
    // Operand B straight through, used by LUI
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // ==========================================================================
  // Exceptions and operand selects
  // ==========================================================================
  // Carried with the instruction and reported at retirement
  typedef enum logic {
    EXC_NONE    = 1'b0,
    EXC_ILLEGAL = 1'b1
  } exc_e;

  // Second ALU operand source
  typedef enum logic {
    SRC_B_REG = 1'b0,
    SRC_B_IMM = 1'b1
  } src_b_e;

endpackage

// File: verilog/rv_decoder.sv
// Decode stage; turns the instruction in the decode register into controls and an immediate
`timescale 1ns/1ps
module rv_decoder
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  instr_t    instr_i,
  input  logic      valid_i,
  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  output reg_addr_t rd_addr_o,
  output alu_op_e   alu_op_o,
  output src_b_e    src_b_o,
  output logic      use_rs1_o,
  output word_t     imm_o,
  output logic      rf_write_o,
  output exc_e      exc_o
);

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  logic    illegal;
  word_t   imm_i_type;
  word_t   imm_u_type;

  // Map funct3 onto an ALU operation, alt picks SUB or SRA
  function automatic alu_op_e funct3_op(funct3_t f3, logic alt);
    alu_op_e op;
    case (f3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SR:      op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      default:    op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = instr_opcode(instr_i);
  assign funct3 = instr_funct3(instr_i);
  assign funct7 = instr_funct7(instr_i);

  // Register addresses go to the register file without decoding
  assign rs1_addr_o = instr_rs1(instr_i);
  assign rs2_addr_o = instr_rs2(instr_i);
  assign rd_addr_o  = instr_rd(instr_i);

  // I-type, sign taken from bit 31
  assign imm_i_type = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  // U-type, upper 20 bits with zero fill
  assign imm_u_type = {instr_i[31:12], 12'b0};

  // ==========================================================================
  // Opcode decode
  // ==========================================================================
  always_comb begin
    illegal   = 1'b0;
    alu_op_o  = ALU_ADD;
    src_b_o   = SRC_B_REG;
    use_rs1_o = 1'b1;
    imm_o     = imm_i_type;
    case (opcode)
      OPC_OP: begin
        alu_op_o = funct3_op(funct3, funct7 == F7_ALT);
        // Alternate funct7 exists only for SUB and SRA
        if (funct7 == F7_ALT) begin
          illegal = !(funct3 inside {F3_ADD_SUB, F3_SR});
        end else begin
          illegal = (funct7 != F7_BASE);
        end
      end
      OPC_OP_IMM: begin
        src_b_o  = SRC_B_IMM;
        // Upper immediate bits only mean funct7 for the shifts
        alu_op_o = funct3_op(funct3, (funct3 == F3_SR) && (funct7 == F7_ALT));
        if (funct3 == F3_SLL) begin
          illegal = (funct7 != F7_BASE);
        end else if (funct3 == F3_SR) begin
          illegal = !(funct7 inside {F7_BASE, F7_ALT});
        end
      end
      OPC_LUI: begin
        // Zero operand A plus immediate pass-through
        alu_op_o  = ALU_PASS_B;
        src_b_o   = SRC_B_IMM;
        use_rs1_o = 1'b0;
        imm_o     = imm_u_type;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  // Only a valid, legal instruction writes back
  assign rf_write_o = valid_i && !illegal;
  assign exc_o      = (valid_i && illegal) ? EXC_ILLEGAL : EXC_NONE;

endmodule

// File: verilog/rv_regfile.sv
// Integer register file; two combinational read ports and one write port driven from writeback
`timescale 1ns/1ps
module rv_regfile
  import rv_isa_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  input  logic      we_i,
  input  reg_addr_t wr_addr_i,
  input  word_t     wr_data_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o
);

  // x0 has no storage
  word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // ==========================================================================
  // Read ports, x0 first, then same-cycle write bypass
  // ==========================================================================
  always_comb begin
    if (rs1_addr_i == '0) begin
      rs1_data_o = '0;
    end else if (we_i && (rs1_addr_i == wr_addr_i)) begin
      rs1_data_o = wr_data_i;
    end else begin
      rs1_data_o = regs[rs1_addr_i];
    end
  end

  always_comb begin
    if (rs2_addr_i == '0) begin
      rs2_data_o = '0;
    end else if (we_i && (rs2_addr_i == wr_addr_i)) begin
      rs2_data_o = wr_data_i;
    end else begin
      rs2_data_o = regs[rs2_addr_i];
    end
  end

  // Writeback must already have filtered out x0
  assert property (@(posedge clk_i) disable iff (!rst_ni) we_i |-> (wr_addr_i != '0))
    else $error("register write to x0 reached the register file");

endmodule

// File: verilog/rv_execute.sv
// Execute stage; forwards the writeback result into the operands and computes the ALU result
`timescale 1ns/1ps
module rv_execute
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  input  word_t     imm_i,
  input  alu_op_e   alu_op_i,
  input  src_b_e    src_b_i,
  input  logic      use_rs1_i,
  input  logic      wb_we_i,
  input  reg_addr_t wb_rd_i,
  input  word_t     wb_data_i,
  output word_t     result_o
);

  word_t  rs1_val;
  word_t  rs2_val;
  word_t  op_a;
  word_t  op_b;
  shamt_t shamt;

  // Take the writeback result when it targets this source
  function automatic word_t fwd_operand(reg_addr_t src, word_t reg_data, logic we,
                                        reg_addr_t rd, word_t rd_data);
    word_t val;
    if (we && (rd != '0) && (rd == src)) begin
      val = rd_data;
    end else begin
      val = reg_data;
    end
    return val;
  endfunction

  // ==========================================================================
  // Operand selection
  // ==========================================================================
  // Distance-one producers sit in writeback now
  assign rs1_val = fwd_operand(rs1_addr_i, rs1_data_i, wb_we_i, wb_rd_i, wb_data_i);
  assign rs2_val = fwd_operand(rs2_addr_i, rs2_data_i, wb_we_i, wb_rd_i, wb_data_i);

  // LUI runs with operand A forced to zero
  assign op_a = use_rs1_i ? rs1_val : '0;
  assign op_b = (src_b_i == SRC_B_IMM) ? imm_i : rs2_val;

  // Low five bits only
  assign shamt = op_b[SHAMT_W-1:0];

  // ==========================================================================
  // ALU
  // ==========================================================================
  always_comb begin
    case (alu_op_i)
      ALU_ADD:    result_o = op_a + op_b;
      ALU_SUB:    result_o = op_a - op_b;
      ALU_AND:    result_o = op_a & op_b;
      ALU_OR:     result_o = op_a | op_b;
      ALU_XOR:    result_o = op_a ^ op_b;
      ALU_SLL:    result_o = op_a << shamt;
      ALU_SRL:    result_o = op_a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:    result_o = word_t'($signed(op_a) >>> shamt);
      ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_PASS_B: result_o = op_b;
      default:    result_o = '0;
    endcase
  end

endmodule

// File: verilog/rv_core.sv
// Top of the integer pipeline; feed instructions as strobes and collect them from the retire port
`timescale 1ns/1ps
module rv_core
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      instr_valid_i,
  input  instr_t    instr_i,
  output logic      retire_valid_o,
  output reg_addr_t retire_rd_o,
  output word_t     retire_data_o,
  output exc_e      retire_exc_o
);

  // Decode register
  logic      dec_valid_q;
  instr_t    dec_instr_q;

  // Decoder and register file outputs
  reg_addr_t dec_rs1_addr;
  reg_addr_t dec_rs2_addr;
  reg_addr_t dec_rd_addr;
  alu_op_e   dec_alu_op;
  src_b_e    dec_src_b;
  logic      dec_use_rs1;
  word_t     dec_imm;
  logic      dec_rf_write;
  exc_e      dec_exc;
  word_t     rf_rs1_data;
  word_t     rf_rs2_data;

  // Execute register
  logic      ex_valid_q;
  logic      ex_rf_write_q;
  exc_e      ex_exc_q;
  alu_op_e   ex_alu_op_q;
  src_b_e    ex_src_b_q;
  logic      ex_use_rs1_q;
  word_t     ex_rs1_data_q;
  word_t     ex_rs2_data_q;
  reg_addr_t ex_rs1_addr_q;
  reg_addr_t ex_rs2_addr_q;
  reg_addr_t ex_rd_q;
  word_t     ex_imm_q;
  word_t     ex_result;

  // Writeback register
  logic      wb_valid_q;
  exc_e      wb_exc_q;
  reg_addr_t wb_rd_q;
  word_t     wb_data_q;
  logic      wb_we;

  // ==========================================================================
  // Decode
  // ==========================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      dec_valid_q <= 1'b0;
    end else begin
      dec_valid_q <= instr_valid_i;
    end
  end

  // Word only loaded on a strobe
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      dec_instr_q <= instr_i;
    end
  end

  rv_decoder i_decoder (
    .instr_i    (dec_instr_q),
    .valid_i    (dec_valid_q),
    .rs1_addr_o (dec_rs1_addr),
    .rs2_addr_o (dec_rs2_addr),
    .rd_addr_o  (dec_rd_addr),
    .alu_op_o   (dec_alu_op),
    .src_b_o    (dec_src_b),
    .use_rs1_o  (dec_use_rs1),
    .imm_o      (dec_imm),
    .rf_write_o (dec_rf_write),
    .exc_o      (dec_exc)
  );

  // Read in decode, written from writeback with bypass
  rv_regfile i_regfile (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rs1_addr_i (dec_rs1_addr),
    .rs2_addr_i (dec_rs2_addr),
    .we_i       (wb_we),
    .wr_addr_i  (wb_rd_q),
    .wr_data_i  (wb_data_q),
    .rs1_data_o (rf_rs1_data),
    .rs2_data_o (rf_rs2_data)
  );

  // ==========================================================================
  // Execute
  // ==========================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ex_valid_q    <= 1'b0;
      ex_rf_write_q <= 1'b0;
      ex_exc_q      <= EXC_NONE;
    end else begin
      ex_valid_q    <= dec_valid_q;
      ex_rf_write_q <= dec_rf_write;
      ex_exc_q      <= dec_exc;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_alu_op_q   <= dec_alu_op;
    ex_src_b_q    <= dec_src_b;
    ex_use_rs1_q  <= dec_use_rs1;
    ex_rs1_data_q <= rf_rs1_data;
    ex_rs2_data_q <= rf_rs2_data;
    ex_rs1_addr_q <= dec_rs1_addr;
    ex_rs2_addr_q <= dec_rs2_addr;
    ex_rd_q       <= dec_rd_addr;
    ex_imm_q      <= dec_imm;
  end

  rv_execute i_execute (
    .rs1_addr_i (ex_rs1_addr_q),
    .rs2_addr_i (ex_rs2_addr_q),
    .rs1_data_i (ex_rs1_data_q),
    .rs2_data_i (ex_rs2_data_q),
    .imm_i      (ex_imm_q),
    .alu_op_i   (ex_alu_op_q),
    .src_b_i    (ex_src_b_q),
    .use_rs1_i  (ex_use_rs1_q),
    .wb_we_i    (wb_we),
    .wb_rd_i    (wb_rd_q),
    .wb_data_i  (wb_data_q),
    .result_o   (ex_result)
  );

  // ==========================================================================
  // Writeback and retirement
  // ==========================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wb_valid_q <= 1'b0;
      wb_exc_q   <= EXC_NONE;
    end else begin
      wb_valid_q <= ex_valid_q;
      wb_exc_q   <= ex_exc_q;
    end
  end

  // Illegal instructions retire with zero data
  always_ff @(posedge clk_i) begin
    wb_rd_q   <= ex_rd_q;
    wb_data_q <= ex_rf_write_q ? ex_result : '0;
  end

  // x0 writes retire but never reach storage
  assign wb_we = wb_valid_q && (wb_exc_q == EXC_NONE) && (wb_rd_q != '0);

  assign retire_valid_o = wb_valid_q;
  assign retire_rd_o    = wb_rd_q;
  assign retire_data_o  = wb_data_q;
  assign retire_exc_o   = wb_exc_q;

  // A live execute stage always carries a defined ALU operation
  assert property (@(posedge clk_i) disable iff (!rst_ni) ex_valid_q |-> !$isunknown(ex_alu_op_q))
    else $error("unknown ALU operation in a valid execute stage");

  // No exception reported on an idle retire port
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   !retire_valid_o |-> (retire_exc_o == EXC_NONE))
    else $error("exception flagged without a retirement");

endmodule

// File: verification/rv_core_tb.sv
// Self-checking testbench for rv_core; issues a table of instructions with random gaps
`timescale 1ns/1ps
module rv_core_tb
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
();

  logic      clk;
  logic      rst_n;
  logic      instr_valid;
  instr_t    instr;
  logic      retire_valid;
  reg_addr_t retire_rd;
  word_t     retire_data;
  exc_e      retire_exc;

  // Stimulus table, one entry per instruction
  string     tbl_name[$];
  instr_t    tbl_instr[$];
  reg_addr_t tbl_rd[$];
  word_t     tbl_data[$];
  exc_e      tbl_exc[$];
  // Set where the entry must follow its predecessor with no idle cycle
  logic      tbl_b2b[$];

  int          issued_count  = 0;
  int          retired_count = 0;
  int          cycle_count   = 0;
  logic [31:0] lfsr_state    = 32'h8217;

  rv_core UUT (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .retire_valid_o (retire_valid),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data),
    .retire_exc_o   (retire_exc)
  );

  always #5 clk = ~clk;

  // ==========================================================================
  // Instruction encoders, RV32I R/I/U formats
  // ==========================================================================
  function automatic instr_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                   reg_addr_t rs1, reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic instr_t enc_i(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                   logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic instr_t enc_u(reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr_state = lfsr_step(lfsr_state);
    b = lfsr_state[0];
  endtask

  // Two bits give 0 to 3 idle cycles
  task automatic draw_gap(output int gap);
    logic hi;
    logic lo;
    take_bit(hi);
    take_bit(lo);
    gap = int'({hi, lo});
  endtask

  task automatic add_row(string name, instr_t word, reg_addr_t rd, word_t data, exc_e exc,
                         logic b2b);
    tbl_name.push_back(name);
    tbl_instr.push_back(word);
    tbl_rd.push_back(rd);
    tbl_data.push_back(data);
    tbl_exc.push_back(exc);
    tbl_b2b.push_back(b2b);
  endtask

  // ==========================================================================
  // Failure reporting and compares
  // ==========================================================================
  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_data(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: data expected 0x%08h, actual 0x%08h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_rd(string name, reg_addr_t exp, reg_addr_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: rd expected x%0d, actual x%0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_exc(string name, exc_e exp, exc_e act);
    if (act !== exp) begin
      $display("[FAIL] %s: exception expected %s, actual %s", name, exp.name(), act.name());
      abort_run();
    end
  endtask

  // ==========================================================================
  // Table, expected values worked out by hand from RV32I rules
  // ==========================================================================
  task automatic build_table();
    // Immediates and LUI, registers start at zero
    add_row("lui", enc_u(5'd1, 20'h12345), 5'd1, 32'h1234_5000, EXC_NONE, 1'b0);
    add_row("addi_m1", enc_i(3'd0, 5'd2, 5'd0, 12'hFFF), 5'd2, 32'hFFFF_FFFF, EXC_NONE, 1'b0);
    add_row("addi_max", enc_i(3'd0, 5'd3, 5'd0, 12'h7FF), 5'd3, 32'h0000_07FF, EXC_NONE, 1'b0);
    add_row("addi_min", enc_i(3'd0, 5'd4, 5'd0, 12'h800), 5'd4, 32'hFFFF_F800, EXC_NONE, 1'b0);
    // Register-register forms
    add_row("add", enc_r(7'h00, 3'd0, 5'd5, 5'd1, 5'd3), 5'd5, 32'h1234_57FF, EXC_NONE, 1'b0);
    add_row("sub", enc_r(7'h20, 3'd0, 5'd6, 5'd3, 5'd1), 5'd6, 32'hEDCB_B7FF, EXC_NONE, 1'b0);
    add_row("and", enc_r(7'h00, 3'd7, 5'd7, 5'd1, 5'd2), 5'd7, 32'h1234_5000, EXC_NONE, 1'b0);
    add_row("or", enc_r(7'h00, 3'd6, 5'd8, 5'd1, 5'd3), 5'd8, 32'h1234_57FF, EXC_NONE, 1'b0);
    add_row("xor", enc_r(7'h00, 3'd4, 5'd9, 5'd5, 5'd2), 5'd9, 32'hEDCB_A800, EXC_NONE, 1'b0);
    // Shift amount 36, only the low five bits count
    add_row("addi_sh", enc_i(3'd0, 5'd11, 5'd0, 12'h024), 5'd11, 32'h24, EXC_NONE, 1'b0);
    add_row("sll", enc_r(7'h00, 3'd1, 5'd10, 5'd3, 5'd11), 5'd10, 32'h7FF0, EXC_NONE, 1'b0);
    add_row("srl", enc_r(7'h00, 3'd5, 5'd12, 5'd4, 5'd11), 5'd12, 32'h0FFF_FF80, EXC_NONE, 1'b0);
    add_row("sra", enc_r(7'h20, 3'd5, 5'd13, 5'd4, 5'd11), 5'd13, 32'hFFFF_FF80, EXC_NONE, 1'b0);
    // Signed against unsigned compare, both directions
    add_row("slt_neg", enc_r(7'h00, 3'd2, 5'd14, 5'd4, 5'd3), 5'd14, 32'd1, EXC_NONE, 1'b0);
    add_row("sltu_big", enc_r(7'h00, 3'd3, 5'd15, 5'd4, 5'd3), 5'd15, 32'd0, EXC_NONE, 1'b0);
    add_row("slt_pos", enc_r(7'h00, 3'd2, 5'd16, 5'd3, 5'd4), 5'd16, 32'd0, EXC_NONE, 1'b0);
    add_row("sltu_small", enc_r(7'h00, 3'd3, 5'd17, 5'd3, 5'd4), 5'd17, 32'd1, EXC_NONE, 1'b0);
    // Immediate ALU forms
    add_row("andi", enc_i(3'd7, 5'd18, 5'd5, 12'h7F0), 5'd18, 32'h7F0, EXC_NONE, 1'b0);
    add_row("andi_neg", enc_i(3'd7, 5'd19, 5'd5, 12'hFF0), 5'd19, 32'h1234_57F0, EXC_NONE, 1'b0);
    add_row("ori", enc_i(3'd6, 5'd20, 5'd1, 12'h0F0), 5'd20, 32'h1234_50F0, EXC_NONE, 1'b0);
    add_row("xori_not", enc_i(3'd4, 5'd21, 5'd1, 12'hFFF), 5'd21, 32'hEDCB_AFFF, EXC_NONE, 1'b0);
    add_row("slti", enc_i(3'd2, 5'd22, 5'd4, 12'hFFF), 5'd22, 32'd1, EXC_NONE, 1'b0);
    add_row("sltiu", enc_i(3'd3, 5'd23, 5'd3, 12'hFFF), 5'd23, 32'd1, EXC_NONE, 1'b0);
    add_row("sltiu_big", enc_i(3'd3, 5'd24, 5'd2, 12'h005), 5'd24, 32'd0, EXC_NONE, 1'b0);
    add_row("slli", enc_i(3'd1, 5'd26, 5'd2, 12'h01F), 5'd26, 32'h8000_0000, EXC_NONE, 1'b0);
    add_row("srli", enc_i(3'd5, 5'd27, 5'd2, 12'h01C), 5'd27, 32'hF, EXC_NONE, 1'b0);
    add_row("srai_pos", enc_i(3'd5, 5'd28, 5'd1, 12'h408), 5'd28, 32'h0012_3450, EXC_NONE, 1'b0);
    add_row("srai_neg", enc_i(3'd5, 5'd29, 5'd4, 12'h403), 5'd29, 32'hFFFF_FF00, EXC_NONE, 1'b0);
    // Dependent chain, distance one forwards and distance two writes through
    add_row("fwd_base", enc_i(3'd0, 5'd30, 5'd0, 12'h064), 5'd30, 32'h64, EXC_NONE, 1'b0);
    add_row("fwd_rs1", enc_i(3'd0, 5'd30, 5'd30, 12'h005), 5'd30, 32'h69, EXC_NONE, 1'b1);
    add_row("fwd_rs2", enc_r(7'h00, 3'd0, 5'd31, 5'd0, 5'd30), 5'd31, 32'h69, EXC_NONE, 1'b1);
    add_row("wt_rs1", enc_r(7'h00, 3'd4, 5'd29, 5'd30, 5'd0), 5'd29, 32'h69, EXC_NONE, 1'b1);
    add_row("wt_rs2", enc_r(7'h20, 3'd0, 5'd28, 5'd0, 5'd31), 5'd28, 32'hFFFF_FF97, EXC_NONE, 1'b1);
    add_row("fwd_mix", enc_r(7'h20, 3'd0, 5'd27, 5'd29, 5'd28), 5'd27, 32'hD2, EXC_NONE, 1'b1);
    add_row("fwd_both", enc_r(7'h00, 3'd0, 5'd26, 5'd27, 5'd27), 5'd26, 32'h1A4, EXC_NONE, 1'b1);
    // x0 takes the write on the retire port only
    add_row("x0_write", enc_i(3'd0, 5'd0, 5'd1, 12'h001), 5'd0, 32'h1234_5001, EXC_NONE, 1'b0);
    add_row("x0_read", enc_i(3'd6, 5'd24, 5'd0, 12'h123), 5'd24, 32'h123, EXC_NONE, 1'b1);
    add_row("x0_add", enc_r(7'h00, 3'd0, 5'd23, 5'd0, 5'd1), 5'd23, 32'h1234_5000, EXC_NONE, 1'b0);
    // Illegal encodings, then reads of their destinations
    add_row("ill_load", 32'h0000_2283, 5'd5, 32'd0, EXC_ILLEGAL, 1'b0);
    add_row("ill_mul", enc_r(7'h01, 3'd0, 5'd1, 5'd1, 5'd2), 5'd1, 32'd0, EXC_ILLEGAL, 1'b1);
    add_row("after_ill", enc_r(7'h00, 3'd0, 5'd9, 5'd1, 5'd5), 5'd9, 32'h2468_A7FF, EXC_NONE, 1'b1);
    add_row("ill_and_alt", enc_r(7'h20, 3'd7, 5'd7, 5'd1, 5'd2), 5'd7, 32'd0, EXC_ILLEGAL, 1'b0);
    add_row("ill_slli", enc_i(3'd1, 5'd3, 5'd1, 12'h401), 5'd3, 32'd0, EXC_ILLEGAL, 1'b1);
    add_row("ill_srli", enc_i(3'd5, 5'd8, 5'd1, 12'h021), 5'd8, 32'd0, EXC_ILLEGAL, 1'b1);
    add_row("ill_zero", 32'h0000_0000, 5'd0, 32'd0, EXC_ILLEGAL, 1'b1);
    add_row("keep_rd", enc_r(7'h00, 3'd6, 5'd10, 5'd7, 5'd3), 5'd10, 32'h1234_57FF, EXC_NONE, 1'b1);
    add_row("keep_rd2", enc_r(7'h00, 3'd4, 5'd11, 5'd8, 5'd9), 5'd11, 32'h365C_F000, EXC_NONE, 1'b0);
    // LUI with the sign bit set, consumed at once
    add_row("lui_neg", enc_u(5'd12, 20'hFFFFF), 5'd12, 32'hFFFF_F000, EXC_NONE, 1'b0);
    add_row("lui_fwd", enc_i(3'd0, 5'd13, 5'd12, 12'hFFF), 5'd13, 32'hFFFF_EFFF, EXC_NONE, 1'b1);
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  initial begin
    int gap;
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    build_table();
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < tbl_instr.size(); i++) begin
      if (!tbl_b2b[i]) begin
        draw_gap(gap);
        instr_valid = 1'b0;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
      instr_valid = 1'b1;
      instr       = tbl_instr[i];
      @(posedge clk);
      issued_count++;
      #1;
    end
    instr_valid = 1'b0;
    instr       = '0;
    // Drain, then a few quiet cycles to catch stray strobes
    wait (retired_count == tbl_instr.size());
    repeat (4) @(posedge clk);
    $display("All tests passed");
    $finish;
  end

  // ==========================================================================
  // Retire collector, sampled on the falling edge where outputs are settled
  // ==========================================================================
  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      if (retire_valid !== 1'b0) begin
        $display("Retire strobe seen while reset was asserted");
        abort_run();
      end
    end else if (retire_valid === 1'b1) begin
      if (retired_count >= tbl_instr.size()) begin
        $display("Retirement beyond the end of the instruction table");
        abort_run();
      end else if (retired_count >= issued_count) begin
        $display("Retirement with no instruction issued for it");
        abort_run();
      end else begin
        check_rd(tbl_name[retired_count], tbl_rd[retired_count], retire_rd);
        check_data(tbl_name[retired_count], tbl_data[retired_count], retire_data);
        check_exc(tbl_name[retired_count], tbl_exc[retired_count], retire_exc);
        retired_count++;
      end
    end else if (retire_valid !== 1'b0) begin
      $display("Retire strobe is unknown after reset");
      abort_run();
    end
  end

  // Watchdog, four cycles per entry plus reset and drain
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= 4 * tbl_instr.size() + 40) begin
      $display("Timeout after %0d cycles with %0d retired", cycle_count, retired_count);
      abort_run();
    end
  end

endmodule

// File: rv_core.f
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_core.sv
verification/rv_core_tb.sv

// File: Makefile
# Verilator build and run for the integer pipeline testbench
OBJ_DIR = obj_dir

.PHONY: all run lint clean

all: run

# Build the testbench and run it, the exit status carries pass or fail
run:
	verilator --binary --timing --assert --top-module rv_core_tb \
		-f rv_core.f --Mdir $(OBJ_DIR) -o Vrv_core_tb
	./$(OBJ_DIR)/Vrv_core_tb

# Lint the design top on its own
lint:
	verilator --lint-only -Wall --top-module rv_core \
		verilog/rv_isa_pkg.sv verilog/rv_pipe_pkg.sv verilog/rv_decoder.sv \
		verilog/rv_regfile.sv verilog/rv_execute.sv verilog/rv_core.sv

clean:
	rm -rf $(OBJ_DIR)
